/* Makefile */
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_csr.sv
source/rv_core_top.sv
testbench/tb_rv_core.sv

/* source/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  logic [3:0]              alu_func,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [2:0]              branch_type,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    always_comb begin
        case (alu_func)
            alu_add:            result = a + b;
            alu_sub:            result = a - b;
            alu_sll:            result = a << b[4:0];
            alu_slt:            result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:           result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:            result = a ^ b;
            alu_srl:            result = a >> b[4:0];
            alu_sra:            result = $signed(a) >>> b[4:0];
            alu_or, alu_or_csr: result = a | b;
            alu_and:            result = a & b;
            alu_pass_b:         result = b;  // lui
            default:            result = '0;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (branch_type)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  branch_taken = rs1_data < rs2_data;
            3'b111:  branch_taken = rs1_data >= rs2_data;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    imem_req,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic                    imem_resp,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    input  logic                    dmem_resp,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    retire_valid,
    output logic [rv_pkg::xlen-1:0] retire_pc,
    output logic [4:0]              retire_rd,
    output logic                    retire_we,
    output logic [rv_pkg::xlen-1:0] retire_data
);
    import rv_pkg::*;

    inst_u           inst;
    logic [xlen-1:0] pc, imm, jump_pc, wb_data;
    logic [xlen-1:0] alu_a, alu_b, alu_result;
    logic [xlen-1:0] rs1_data, rs2_data, csr_rdata, trap_pc, mem_rdata;
    logic            a_sel;
    logic [1:0]      b_sel, wb_sel;
    logic [3:0]      alu_func;
    logic [2:0]      branch_type;
    logic            is_branch, branch_taken, rd_we, mem_op, mem_we;
    logic            csr_we, csr_or, csr_wr;
    logic            jump_jal, jump_ecall, jump_mret, jump_en;
    logic            exec, retire, mem_done;

    assign alu_a = (a_sel == a_sel_rs1) ? rs1_data : pc;

    always_comb begin
        case (b_sel)
            b_sel_rs2:  alu_b = rs2_data;
            b_sel_csr:  alu_b = csr_rdata;
            b_sel_zero: alu_b = '0;
            default:    alu_b = imm;
        endcase
    end

    always_comb begin
        case (wb_sel)
            wb_csr:  wb_data = csr_rdata;  // old csr value
            wb_pc4:  wb_data = pc + xlen'(4);
            wb_alu:  wb_data = alu_result;
            default: wb_data = mem_rdata;
        endcase
    end

    // jalr clears bit 0, branch targets are already even
    assign jump_en = jump_jal || (is_branch && branch_taken) || jump_ecall || jump_mret;
    assign jump_pc = (jump_ecall || jump_mret) ? trap_pc : {alu_result[xlen-1:1], 1'b0};

    assign csr_wr = csr_we && !(csr_or && inst.r.rs1 == 5'd0);  // csrrs x0 only reads

    assign retire_valid = retire;
    assign retire_pc    = pc;
    assign retire_rd    = inst.r.rd;
    assign retire_we    = retire && rd_we;
    assign retire_data  = wb_data;

    rv_fetch i_rv_fetch (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_resp, .imem_data,
        .mem_op, .mem_done, .jump_en, .jump_pc, .pc, .inst, .exec, .retire
    );

    rv_decode i_rv_decode (
        .inst, .a_sel, .b_sel, .wb_sel, .alu_func, .branch_type, .is_branch,
        .rd_we, .mem_op, .mem_we, .csr_we, .csr_or, .jump_jal, .jump_ecall,
        .jump_mret, .imm
    );

    rv_regfile i_rv_regfile (
        .clk, .rst_n,
        .rs1_addr (inst.r.rs1),
        .rs2_addr (inst.r.rs2),
        .rd_addr  (inst.r.rd),
        .we       (retire && rd_we),
        .wdata    (wb_data),
        .rs1_data, .rs2_data
    );

    rv_alu i_rv_alu (
        .a (alu_a), .b (alu_b), .alu_func, .rs1_data, .rs2_data, .branch_type,
        .result (alu_result), .branch_taken
    );

    rv_lsu i_rv_lsu (
        .clk, .rst_n,
        .start (exec && mem_op),
        .we    (mem_we),
        .addr  (alu_result),
        .wdata (rs2_data),
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_resp, .dmem_rdata,
        .rdata (mem_rdata),
        .mem_done
    );

    rv_csr i_rv_csr (
        .clk, .rst_n, .pc,
        .addr    (inst.i.imm_hi),
        .wdata   (alu_result),
        .we      (csr_wr),
        .ecall   (jump_ecall),
        .mret    (jump_mret),
        .retire,
        .rdata   (csr_rdata),
        .trap_pc
    );

endmodule

/* source/rv_csr.sv */
`timescale 1ns/1ps

module rv_csr (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [11:0]             addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic                    we,
    input  logic                    ecall,
    input  logic                    mret,
    input  logic                    retire,
    output logic [rv_pkg::xlen-1:0] rdata,
    output logic [rv_pkg::xlen-1:0] trap_pc
);
    import rv_pkg::*;

    logic [xlen-1:0] mtvec, mepc, mcause, mscratch;

    always_comb begin
        case (addr)
            csr_mtvec:    rdata = mtvec;
            csr_mepc:     rdata = mepc;
            csr_mcause:   rdata = mcause;
            csr_mscratch: rdata = mscratch;
            default:      rdata = '0;
        endcase
    end

    assign trap_pc = mret ? mepc : mtvec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (retire) begin
            if (ecall) begin  // trap entry
                mepc   <= pc;
                mcause <= cause_ecall_m;
            end else if (we) begin
                case (addr)
                    csr_mtvec:    mtvec    <= wdata;
                    csr_mepc:     mepc     <= wdata;
                    csr_mcause:   mcause   <= wdata;
                    csr_mscratch: mscratch <= wdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  rv_pkg::inst_u           inst,
    output logic                    a_sel,
    output logic [1:0]              b_sel,
    output logic [1:0]              wb_sel,
    output logic [3:0]              alu_func,
    output logic [2:0]              branch_type,
    output logic                    is_branch,
    output logic                    rd_we,
    output logic                    mem_op,
    output logic                    mem_we,
    output logic                    csr_we,
    output logic                    csr_or,
    output logic                    jump_jal,
    output logic                    jump_ecall,
    output logic                    jump_mret,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [3:0]      alu_arith;
    logic            alt;  // sub or sra

    assign imm_i = {{20{inst.i.imm_hi[11]}}, inst.i.imm_hi};
    assign imm_s = {{20{inst.i.imm_hi[11]}}, inst.i.imm_hi[11:5], inst.i.imm_lo};
    assign imm_b = {{20{inst.i.imm_hi[11]}}, inst.i.imm_lo[0], inst.i.imm_hi[10:5],
                    inst.i.imm_lo[4:1], 1'b0};
    assign imm_u = {inst.i.imm_hi, inst.i.rs1, inst.i.funct3, 12'b0};
    assign imm_j = {{12{inst.i.imm_hi[11]}}, inst.i.rs1, inst.i.funct3,
                    inst.i.imm_hi[0], inst.i.imm_hi[10:1], 1'b0};

    assign branch_type = inst.r.funct3;

    // srai shares funct7[5] with sub, but addi has no alternate form
    assign alt = inst.r.funct7[5] &&
                 (inst.r.opcode == op_reg || inst.r.funct3 == 3'b101);

    always_comb begin
        case (inst.r.funct3)
            3'b000:  alu_arith = alt ? alu_sub : alu_add;
            3'b001:  alu_arith = alu_sll;
            3'b010:  alu_arith = alu_slt;
            3'b011:  alu_arith = alu_sltu;
            3'b100:  alu_arith = alu_xor;
            3'b101:  alu_arith = alt ? alu_sra : alu_srl;
            3'b110:  alu_arith = alu_or;
            default: alu_arith = alu_and;
        endcase
    end

    always_comb begin
        a_sel      = a_sel_rs1;
        b_sel      = b_sel_imm;
        wb_sel     = wb_alu;
        alu_func   = alu_add;
        imm        = imm_i;
        is_branch  = 1'b0;
        rd_we      = 1'b0;
        mem_op     = 1'b0;
        mem_we     = 1'b0;
        csr_we     = 1'b0;
        csr_or     = 1'b0;
        jump_jal   = 1'b0;
        jump_ecall = 1'b0;
        jump_mret  = 1'b0;
        case (inst.r.opcode)
            op_lui: begin
                imm      = imm_u;
                alu_func = alu_pass_b;
                rd_we    = 1'b1;
            end
            op_auipc: begin
                a_sel = a_sel_pc;
                imm   = imm_u;
                rd_we = 1'b1;
            end
            op_jal: begin
                a_sel    = a_sel_pc;
                imm      = imm_j;
                wb_sel   = wb_pc4;
                rd_we    = 1'b1;
                jump_jal = 1'b1;
            end
            op_jalr: begin
                wb_sel   = wb_pc4;
                rd_we    = 1'b1;
                jump_jal = 1'b1;
            end
            op_branch: begin
                a_sel     = a_sel_pc;  // target computed by alu
                imm       = imm_b;
                is_branch = 1'b1;
            end
            op_load: begin
                wb_sel = wb_mem;
                rd_we  = 1'b1;
                mem_op = 1'b1;
            end
            op_store: begin
                imm    = imm_s;
                mem_op = 1'b1;
                mem_we = 1'b1;
            end
            op_imm: begin
                alu_func = alu_arith;
                rd_we    = 1'b1;
            end
            op_reg: begin
                b_sel    = b_sel_rs2;
                alu_func = alu_arith;
                rd_we    = 1'b1;
            end
            op_system: begin
                case (inst.r.funct3)
                    3'b000: begin
                        jump_mret  = (inst.i.imm_hi == funct12_mret);
                        jump_ecall = (inst.i.imm_hi == 12'h000);
                    end
                    3'b001: begin  // csrrw
                        b_sel  = b_sel_zero;
                        wb_sel = wb_csr;
                        rd_we  = 1'b1;
                        csr_we = 1'b1;
                    end
                    3'b010: begin  // csrrs
                        b_sel    = b_sel_csr;
                        alu_func = alu_or_csr;
                        wb_sel   = wb_csr;
                        rd_we    = 1'b1;
                        csr_we   = 1'b1;
                        csr_or   = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* source/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    imem_req,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic                    imem_resp,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    input  logic                    mem_op,
    input  logic                    mem_done,
    input  logic                    jump_en,
    input  logic [rv_pkg::xlen-1:0] jump_pc,
    output logic [rv_pkg::xlen-1:0] pc,
    output rv_pkg::inst_u           inst,
    output logic                    exec,
    output logic                    retire
);
    import rv_pkg::*;

    logic [1:0] state;
    logic       boot;    // first cycle out of reset
    logic       credit;  // one outstanding fetch at most

    assign imem_addr = pc;
    assign exec      = (state == st_exec);
    assign retire    = (exec && !mem_op) || (state == st_mem && mem_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_fetch;
            boot     <= 1'b1;
            credit   <= 1'b1;
            imem_req <= 1'b0;
            pc       <= reset_pc;
        end else begin
            boot     <= 1'b0;
            imem_req <= (boot || retire) && credit;
            if (imem_req) begin
                credit <= 1'b0;  // spent by the request
            end else if (imem_resp) begin
                credit <= 1'b1;  // returned with the instruction
            end
            case (state)
                st_fetch: if (imem_resp) state <= st_exec;
                st_exec:  state <= mem_op ? st_mem : st_fetch;
                st_mem:   if (mem_done) state <= st_fetch;
                default:  state <= st_fetch;
            endcase
            if (retire) begin
                pc <= jump_en ? jump_pc : pc + xlen'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_resp) begin
            inst <= imem_data;
        end
    end

endmodule

/* source/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    input  logic                    dmem_resp,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_pkg::xlen-1:0] rdata,
    output logic                    mem_done
);
    logic credit;  // data port credit

    assign dmem_req   = start && credit;
    assign dmem_we    = dmem_req && we;
    assign dmem_addr  = {addr[31:2], 2'b00};  // word access only
    assign dmem_wdata = wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit   <= 1'b1;
            mem_done <= 1'b0;
        end else begin
            mem_done <= dmem_resp;
            if (dmem_req) begin
                credit <= 1'b0;
            end else if (dmem_resp) begin
                credit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_resp) begin
            rdata <= dmem_rdata;  // held for write-back
        end
    end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // base opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10;
    localparam logic [3:0] alu_or_csr = 4'd11;  // rs1 set bits into csr value

    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;
    localparam logic [11:0] funct12_mret = 12'h302;

    localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

    // operand and write-back selects
    localparam logic       a_sel_pc   = 1'b0;
    localparam logic       a_sel_rs1  = 1'b1;
    localparam logic [1:0] b_sel_rs2  = 2'b00;
    localparam logic [1:0] b_sel_csr  = 2'b01;
    localparam logic [1:0] b_sel_zero = 2'b10;
    localparam logic [1:0] b_sel_imm  = 2'b11;
    localparam logic [1:0] wb_csr     = 2'b00;
    localparam logic [1:0] wb_pc4     = 2'b01;
    localparam logic [1:0] wb_alu     = 2'b10;
    localparam logic [1:0] wb_mem     = 2'b11;

    // fetch sequencer states
    localparam logic [1:0] st_fetch = 2'd0;
    localparam logic [1:0] st_exec  = 2'd1;
    localparam logic [1:0] st_mem   = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_hi;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } i;
    } inst_u;

endpackage

/* source/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin  // x0 stays zero
            regs[rd_addr] <= wdata;
        end
    end

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int max_rows = 40;

    logic        clk;
    logic        rst_n = 1'b0;
    logic        imem_req, dmem_req, dmem_we, retire_valid, retire_we;
    logic [31:0] imem_addr, dmem_addr, dmem_wdata, retire_pc, retire_data;
    logic [4:0]  retire_rd;
    logic        imem_resp = 1'b0;
    logic        dmem_resp = 1'b0;
    logic [31:0] imem_data = '0;
    logic [31:0] dmem_rdata = '0;

    // one row per retired instruction in execution order
    string       row_name    [max_rows];
    logic [31:0] row_pc      [max_rows];
    logic [31:0] row_inst    [max_rows];
    logic [4:0]  row_rd      [max_rows];
    logic        row_we      [max_rows];
    logic [31:0] row_data    [max_rows];  // store data on sw rows
    logic        row_st      [max_rows];
    logic [31:0] row_st_addr [max_rows];
    int          n_rows = 0;
    logic        rows_ready = 1'b0;

    logic [31:0] lfsr = 32'h5b732194;
    logic [31:0] dmem [64];
    logic        i_busy = 1'b0;  // fetch outstanding at the model
    logic        d_busy = 1'b0;
    int          i_wait, d_wait;
    logic [31:0] i_addr, d_rdata_q;
    int          st_count = 0;
    logic [31:0] st_addr_seen, st_data_seen;
    int          port_errs = 0;
    int          test_fails = 0;
    int          n_tests = 0;
    logic        test_bad = 1'b0;

    rv_core_top i_rv_core_top (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_resp, .imem_data,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_resp, .dmem_rdata,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic draw_delay(output int d);
        lfsr = lfsr_next(lfsr);
        d = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        d = 2 * d + int'(lfsr[0]) + 1;  // 1 to 4 cycles
    endtask

    // instruction encoders with field order from the RV32I formats
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    task automatic add_row(string name, int pc, logic [31:0] inst, int rd, int we, int data);
        row_name[n_rows] = name;
        row_pc[n_rows]   = pc;
        row_inst[n_rows] = inst;
        row_rd[n_rows]   = 5'(rd);
        row_we[n_rows]   = (we != 0);
        row_data[n_rows] = data;
        row_st[n_rows]   = 1'b0;
        n_rows++;
    endtask

    task automatic mark_store(int addr);
        row_st[n_rows - 1]      = 1'b1;
        row_st_addr[n_rows - 1] = addr;
    endtask

    task automatic build_table();
        add_row("addi x1", 'h000, enc_i(5, 0, 0, 1, op_imm), 1, 1, 5);
        add_row("addi x2", 'h004, enc_i(-3, 0, 0, 2, op_imm), 2, 1, -3);
        add_row("add", 'h008, enc_r(0, 2, 1, 0, 3, op_reg), 3, 1, 2);
        add_row("sub", 'h00c, enc_r('h20, 2, 1, 0, 4, op_reg), 4, 1, 8);
        add_row("slt", 'h010, enc_r(0, 1, 2, 2, 5, op_reg), 5, 1, 1);
        add_row("sra", 'h014, enc_r('h20, 1, 2, 5, 6, op_reg), 6, 1, -1);
        add_row("xori", 'h018, enc_i('h0f0, 1, 4, 7, op_imm), 7, 1, 'hf5);
        add_row("lui", 'h01c, enc_u('h12345, 8, op_lui), 8, 1, 'h12345000);
        add_row("auipc", 'h020, enc_u('h00001, 9, op_auipc), 9, 1, 'h1020);
        add_row("addi x0", 'h024, enc_i(7, 1, 0, 0, op_imm), 0, 1, 12);  // result dropped
        add_row("read x0", 'h028, enc_r(0, 1, 0, 0, 10, op_reg), 10, 1, 5);
        add_row("beq not taken", 'h02c, enc_b(8, 2, 1, 0), 0, 0, 0);
        add_row("bne taken", 'h030, enc_b(12, 2, 1, 1), 0, 0, 0);
        add_row("jal", 'h03c, enc_j(12, 11), 11, 1, 'h40);
        add_row("addi x12", 'h048, enc_i('h60, 0, 0, 12, op_imm), 12, 1, 'h60);
        add_row("jalr", 'h04c, enc_i(4, 12, 0, 13, op_jalr), 13, 1, 'h50);
        add_row("addi x14", 'h064, enc_i('h100, 0, 0, 14, op_imm), 14, 1, 'h100);
        add_row("sw", 'h068, enc_s(8, 1, 14), 0, 0, 5);
        mark_store('h108);
        add_row("lw", 'h06c, enc_i(8, 14, 2, 15, op_load), 15, 1, 5);
        add_row("addi x16", 'h070, enc_i('h200, 0, 0, 16, op_imm), 16, 1, 'h200);
        add_row("csrrw mtvec", 'h074, enc_i('h305, 16, 1, 0, op_system), 0, 1, 0);
        add_row("csrrw mscratch", 'h078, enc_i('h340, 1, 1, 17, op_system), 17, 1, 0);
        add_row("csrrw mscratch old", 'h07c, enc_i('h340, 2, 1, 18, op_system), 18, 1, 5);
        add_row("ecall", 'h080, enc_i(0, 0, 0, 0, op_system), 0, 0, 0);
        add_row("csrrs mepc", 'h200, enc_i('h341, 0, 2, 19, op_system), 19, 1, 'h80);
        add_row("csrrs mcause", 'h204, enc_i('h342, 0, 2, 20, op_system), 20, 1, 11);
        add_row("addi x19", 'h208, enc_i(4, 19, 0, 19, op_imm), 19, 1, 'h84);
        add_row("csrrw mepc", 'h20c, enc_i('h341, 19, 1, 0, op_system), 0, 1, 'h80);
        add_row("mret", 'h210, enc_i('h302, 0, 0, 0, op_system), 0, 0, 0);
        add_row("csrrs mscratch", 'h084, enc_i('h340, 0, 2, 21, op_system), 21, 1, -3);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        for (int k = 0; k < n_rows; k++) begin
            if (row_pc[k] == addr)
                return row_inst[k];
        end
        return 32'h0000_0013;  // nop outside the table
    endfunction

    // both memories answer on the falling edge after a random delay
    always @(negedge clk) begin
        int d;
        imem_resp <= 1'b0;
        dmem_resp <= 1'b0;
        if (!rst_n) begin
            for (int k = 0; k < 64; k++) begin
                dmem[k] = 32'ha500_0000 ^ (k * 4);  // pattern from byte address
            end
        end
        // a request before the previous response is a credit violation
        if (imem_req && i_busy) begin
            $display("fetch request issued while another one is outstanding");
            port_errs++;
        end
        if (dmem_req && d_busy) begin
            $display("data request issued while another one is outstanding");
            port_errs++;
        end
        if (i_busy) begin
            if (i_wait == 0) begin
                imem_resp <= 1'b1;
                imem_data <= fetch_word(i_addr);
                i_busy = 1'b0;
            end else begin
                i_wait--;
            end
        end
        if (imem_req) begin
            i_busy = 1'b1;
            i_addr = imem_addr;
            draw_delay(d);
            i_wait = d - 1;
        end
        if (d_busy) begin
            if (d_wait == 0) begin
                dmem_resp  <= 1'b1;
                dmem_rdata <= d_rdata_q;
                d_busy = 1'b0;
            end else begin
                d_wait--;
            end
        end
        if (dmem_req) begin
            d_busy = 1'b1;
            d_rdata_q = dmem[dmem_addr[7:2]];
            if (dmem_we) begin
                dmem[dmem_addr[7:2]] = dmem_wdata;
                st_count++;
                st_addr_seen = dmem_addr;
                st_data_seen = dmem_wdata;
            end
            draw_delay(d);
            d_wait = d - 1;
        end
    end

    task automatic report_fail(string name, string what, logic [31:0] exp, logic [31:0] act);
        $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
        test_bad = 1'b1;
    endtask

    task automatic finish_test(string name);
        n_tests++;
        if (test_bad)
            test_fails++;
        else
            $display("PASS %s", name);
        test_bad = 1'b0;
    endtask

    task automatic wait_fetch();
        @(negedge clk);
        while (!imem_req) @(negedge clk);
    endtask

    task automatic wait_retire();
        @(negedge clk);
        while (!retire_valid) @(negedge clk);
    endtask

    initial begin
        logic [31:0] exp_next;
        string       name;
        int          stores;
        stores = 0;
        rst_n = 1'b0;
        build_table();
        rows_ready = 1'b1;
        repeat (16) begin
            @(negedge clk);
            if (imem_req || dmem_req) begin
                $display("reset: memory request issued while rst_n is low");
                test_bad = 1'b1;
            end
        end
        rst_n = 1'b1;
        wait_fetch();
        if (imem_addr !== 32'h0)
            report_fail("reset", "first fetch", 32'h0, imem_addr);
        finish_test("reset");

        for (int i = 0; i < n_rows; i++) begin
            name = row_name[i];
            wait_retire();
            if (retire_pc !== row_pc[i])
                report_fail(name, "retire_pc", row_pc[i], retire_pc);
            if (retire_we !== row_we[i])
                report_fail(name, "retire_we", 32'(row_we[i]), 32'(retire_we));
            if (row_we[i] && retire_rd !== row_rd[i])
                report_fail(name, "retire_rd", 32'(row_rd[i]), 32'(retire_rd));
            if (row_we[i] && retire_data !== row_data[i])
                report_fail(name, "retire_data", row_data[i], retire_data);
            if (row_st[i]) begin
                stores++;
                if (st_count != stores) begin
                    $display("%s: no store reached the data port", name);
                    test_bad = 1'b1;
                end else begin
                    if (st_addr_seen !== row_st_addr[i])
                        report_fail(name, "store addr", row_st_addr[i], st_addr_seen);
                    if (st_data_seen !== row_data[i])
                        report_fail(name, "store data", row_data[i], st_data_seen);
                end
            end
            exp_next = (i + 1 < n_rows) ? row_pc[i + 1] : row_pc[i] + 32'd4;
            wait_fetch();
            if (imem_addr !== exp_next)
                report_fail(name, "next pc", exp_next, imem_addr);
            if (!row_st[i] && st_count != stores) begin
                $display("%s: unexpected write on the data port", name);
                test_bad = 1'b1;
                stores = st_count;
            end
            finish_test(name);
        end

        $display("%0d tests, %0d failed, %0d port errors", n_tests, test_fails, port_errs);
        if (test_fails == 0 && port_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog allows reset plus 20 cycles per table row
    initial begin
        wait (rows_ready);
        repeat (16 + n_rows * 20) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", 16 + n_rows * 20);
        $display("Checks failed");
        $finish;
    end

endmodule
